//--- rtl/vc_consts.svh
`ifndef VC_CONSTS_SVH
`define VC_CONSTS_SVH

// sizes shared by the victim cache and its packages.

// line address width.
// 32-bit byte address with 32-byte lines leaves 27 bits.
`define VC_TAG_BITS 27

// one full line of data, 32 bytes.
`define VC_LINE_BITS 256

// number of ways. the way logic is written for exactly four.
`define VC_WAYS 4

`endif

//--- rtl/vc_line_pkg.sv
`default_nettype none
`include "vc_consts.svh"

// data-carrying types for the l1 port, the memory port and the way store.
package vc_line_pkg;

	// one stored or transferred line.
	typedef struct packed
	{
		logic [`VC_TAG_BITS-1:0] tag;   // line address.
		logic [`VC_LINE_BITS-1:0] data; // line payload.
	} vc_line_t;

	// request from the l1 on a miss, carrying the line it is evicting.
	typedef struct packed
	{
		logic [`VC_TAG_BITS-1:0] miss_tag;   // line the l1 wants.
		logic evict_valid;                   // low when the l1 has nothing to evict.
		logic evict_dirty;                   // evicted line differs from memory.
		logic [`VC_TAG_BITS-1:0] evict_tag;  // address of the evicted line.
		logic [`VC_LINE_BITS-1:0] evict_data;
	} vc_req_t;

	// line returned to the l1.
	typedef struct packed
	{
		logic [`VC_LINE_BITS-1:0] data;
	} vc_resp_t;

	// memory transaction, a writeback or a fetch.
	typedef struct packed
	{
		logic write;                    // 1 for writeback, 0 for fetch.
		logic [`VC_TAG_BITS-1:0] tag;
		logic [`VC_LINE_BITS-1:0] data; // unused on a fetch.
	} mem_req_t;

	// read data from memory.
	typedef struct packed
	{
		logic [`VC_LINE_BITS-1:0] data;
	} mem_resp_t;

endpackage : vc_line_pkg

`default_nettype wire

//--- rtl/vc_ctrl_pkg.sv
`default_nettype none
`include "vc_consts.svh"

// control types for the sequencer and the way logic.
package vc_ctrl_pkg;

	// controller states.
	typedef enum logic [2:0]
	{
		IDLE,      // waiting for an l1 request.
		LOOKUP,    // tag compare and victim choice.
		WRITEBACK, // dirty victim goes out to memory.
		FETCH,     // missing line comes in from memory.
		UPDATE,    // evicted line written into its way.
		RESPOND    // ack held until the l1 drops req.
	} vc_state_t;

	// way index.
	typedef logic [$clog2(`VC_WAYS)-1:0] vc_way_t;

	// one bit per way, one-hot or zero where it selects.
	typedef logic [`VC_WAYS-1:0] vc_way_mask_t;

endpackage : vc_ctrl_pkg

`default_nettype wire

//--- rtl/victim_cache_tag_match.sv
`timescale 1ns/10ps
`default_nettype none
`include "vc_consts.svh"

// parallel tag compare over all ways.
module victim_cache_tag_match
(
	input logic [`VC_WAYS-1:0][`VC_TAG_BITS-1:0] tags, // stored tag per way.
	input vc_ctrl_pkg::vc_way_mask_t valid,           // way holds a line.
	input logic [`VC_TAG_BITS-1:0] miss_tag,          // tag the l1 asks for.
	output vc_ctrl_pkg::vc_way_mask_t hit_way         // one bit per matching way.
);

	vc_ctrl_pkg::vc_way_mask_t tag_eq; // raw compare, before valid gating.

	always_comb
	begin
		for (int i = 0; i < `VC_WAYS; i++)
		begin
			tag_eq[i] = (tags[i] == miss_tag);
		end
	end

	// an invalid way never hits, whatever its stale tag says.
	assign hit_way = tag_eq & valid;

	// a tag lives in at most one way.
	// this holds only if the swap path never stores a tag that is already
	// resident, which is the l1's side of the contract.
	hit_way_onehot0 : assert final ($onehot0(hit_way))
	else
		$error("tag_match: tag found in more than one way (%b).", hit_way);

endmodule : victim_cache_tag_match

`default_nettype wire

//--- rtl/victim_cache_plru.sv
`timescale 1ns/10ps
`default_nettype none

// three-bit tree pseudo-lru.
// bit 0 picks the half, bit 1 the way in 0-1, bit 2 the way in 2-3.
module victim_cache_plru
(
	input logic clk,
	input logic rst_n,
	input logic touch,                     // a way was loaded this cycle.
	input vc_ctrl_pkg::vc_way_t new_access, // way that was loaded.
	input vc_ctrl_pkg::vc_way_mask_t valid,
	output vc_ctrl_pkg::vc_way_t lru        // way to replace next.
);

	logic [2:0] tree;             // zero means way 0 is next.
	vc_ctrl_pkg::vc_way_t tree_way; // replacement way from the tree alone.

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tree <= 3'b000;
		end
		else if (touch)
		begin
			// point every bit on the accessed path away from it.
			if (!new_access[1])
			begin
				tree[0] <= 1'b1;           // upper half is next.
				tree[1] <= ~new_access[0]; // the sibling in 0-1.
			end
			else
			begin
				tree[0] <= 1'b0;           // lower half is next.
				tree[2] <= ~new_access[0]; // the sibling in 2-3.
			end
		end
	end

	assign tree_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

	// empty ways fill first, lowest index first.
	always_comb
	begin
		if (!valid[0])
			lru = 2'd0;
		else if (!valid[1])
			lru = 2'd1;
		else if (!valid[2])
			lru = 2'd2;
		else if (!valid[3])
			lru = 2'd3;
		else
			lru = tree_way;
	end

	// with all ways full, the way just used is never the next victim.
	plru_not_mru : assert property (@(posedge clk) disable iff (!rst_n)
		touch && (&valid) |=> lru != $past(new_access))
	else
		$error("plru: just-accessed way %0d named as victim.", lru);

endmodule : victim_cache_plru

`default_nettype wire

//--- rtl/victim_cache_victim_update_logic.sv
`timescale 1ns/10ps
`default_nettype none

// picks the way to load and the way to mark as newly accessed.
// a hit loads its own way, a miss loads the lru way.
module victim_cache_victim_update_logic
(
	input logic update_victim, // high for one cycle in UPDATE.
	input logic [3:0] hit_way, // registered hit mask, zero on a miss.
	input logic [1:0] lru,     // replacement way on a miss.
	output logic [1:0] new_access,
	output logic load0,
	output logic load1,
	output logic load2,
	output logic load3
);

	always_comb
	begin
		// nothing moves outside an update.
		new_access = 2'b00;
		load0 = 1'b0;
		load1 = 1'b0;
		load2 = 1'b0;
		load3 = 1'b0;

		if (update_victim)
		begin
			case (hit_way)
				4'b0000: new_access = lru;   // a miss takes the victim way.
				4'b0001: new_access = 2'b00;
				4'b0010: new_access = 2'b01;
				4'b0100: new_access = 2'b10;
				default: new_access = 2'b11; // way 3.
			endcase

			// decode the chosen way into the load strobes.
			load0 = (new_access == 2'b00);
			load1 = (new_access == 2'b01);
			load2 = (new_access == 2'b10);
			load3 = (new_access == 2'b11);
		end
	end

	// a hit reloads the way that hit and no other.
	load_follows_hit : assert final (!update_victim || hit_way == 4'b0000 ||
		{load3, load2, load1, load0} == hit_way)
	else
		$error("update_logic: load strobes %b do not match hit mask %b.",
			{load3, load2, load1, load0}, hit_way);

endmodule : victim_cache_victim_update_logic

`default_nettype wire

//--- rtl/victim_cache_ways.sv
`timescale 1ns/10ps
`default_nettype none
`include "vc_consts.svh"

// line store for the four ways plus valid and dirty bits.
module victim_cache_ways
(
	input logic clk,
	input logic rst_n,
	input vc_ctrl_pkg::vc_way_mask_t load,     // one-hot write strobe.
	input vc_line_pkg::vc_line_t fill_line,    // line to write.
	input logic fill_dirty,                    // dirty bit of that line.
	output vc_line_pkg::vc_line_t [`VC_WAYS-1:0] lines,
	output vc_ctrl_pkg::vc_way_mask_t valid,
	output vc_ctrl_pkg::vc_way_mask_t dirty
);

	// status bits, cleared so that every way starts empty.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= '0;
			dirty <= '0;
		end
		else
		begin
			for (int i = 0; i < `VC_WAYS; i++)
			begin
				if (load[i])
				begin
					valid[i] <= 1'b1;       // a loaded way always holds a line.
					dirty[i] <= fill_dirty; // dirtiness travels with the line.
				end
			end
		end
	end

	// tag and data, only meaningful while valid.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `VC_WAYS; i++)
		begin
			if (load[i])
			begin
				lines[i] <= fill_line;
			end
		end
	end

	// a fill never lands in two ways at once.
	load_onehot0 : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(load))
	else
		$error("ways: load mask %b is not one-hot.", load);

endmodule : victim_cache_ways

`default_nettype wire

//--- rtl/victim_cache_control.sv
`timescale 1ns/10ps
`default_nettype none
`include "vc_consts.svh"

// sequencer for lookup, writeback, fetch, update and respond.
module victim_cache_control
(
	input logic clk,
	input logic rst_n,
	input logic req,                            // l1 request level.
	input vc_line_pkg::vc_req_t req_data,       // held stable by the l1 until ack.
	output logic ack,
	output vc_line_pkg::vc_resp_t resp,
	output logic mem_req,
	output vc_line_pkg::mem_req_t mem_req_data,
	input logic mem_ack,
	input vc_line_pkg::mem_resp_t mem_resp,
	input vc_ctrl_pkg::vc_way_mask_t hit_way,   // live compare result.
	input vc_ctrl_pkg::vc_way_t lru,            // victim on a miss.
	input vc_line_pkg::vc_line_t [`VC_WAYS-1:0] lines,
	input vc_ctrl_pkg::vc_way_mask_t dirty,
	input vc_ctrl_pkg::vc_way_mask_t valid,
	output vc_ctrl_pkg::vc_way_mask_t hit_way_q, // hit mask held for UPDATE.
	output logic update_victim
);

	vc_ctrl_pkg::vc_state_t state;
	logic lookup_hit;                         // some way matched.
	logic victim_dirty;                       // victim must go to memory first.
	logic [`VC_LINE_BITS-1:0] hit_data;       // data of the matching way.
	vc_line_pkg::mem_req_t wb_req;            // writeback of the victim.
	vc_line_pkg::mem_req_t fetch_req;         // read of the missing line.

	assign lookup_hit = |hit_way;

	// the victim is only replaced when the l1 has a line to put there.
	assign victim_dirty = req_data.evict_valid && valid[lru] && dirty[lru];

	// or-mux, hit_way is one-hot or zero.
	always_comb
	begin
		hit_data = '0;
		for (int i = 0; i < `VC_WAYS; i++)
		begin
			if (hit_way[i])
			begin
				hit_data = hit_data | lines[i].data;
			end
		end
	end

	assign wb_req = '{write: 1'b1, tag: lines[lru].tag, data: lines[lru].data};
	assign fetch_req = '{write: 1'b0, tag: req_data.miss_tag, data: '0};

	// ways load only in UPDATE, and only with a real evicted line.
	assign update_victim = (state == vc_ctrl_pkg::UPDATE) && req_data.evict_valid;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= vc_ctrl_pkg::IDLE;
			ack <= 1'b0;
			mem_req <= 1'b0;
			hit_way_q <= '0;
		end
		else
		begin
			case (state)
				vc_ctrl_pkg::IDLE:
				begin
					if (req)
						state <= vc_ctrl_pkg::LOOKUP;
				end
				vc_ctrl_pkg::LOOKUP:
				begin
					hit_way_q <= hit_way; // zero on a miss, update logic uses lru then.
					if (lookup_hit)
						state <= vc_ctrl_pkg::UPDATE;
					else
					begin
						// writeback first when the victim is dirty.
						state <= victim_dirty ? vc_ctrl_pkg::WRITEBACK : vc_ctrl_pkg::FETCH;
						mem_req <= 1'b1;
					end
				end
				vc_ctrl_pkg::WRITEBACK:
				begin
					if (mem_req && mem_ack)
						mem_req <= 1'b0; // memory took the line.
					else if (!mem_req && !mem_ack)
					begin
						state <= vc_ctrl_pkg::FETCH; // handshake closed, start the read.
						mem_req <= 1'b1;
					end
				end
				vc_ctrl_pkg::FETCH:
				begin
					if (mem_req && mem_ack)
						mem_req <= 1'b0; // read data captured below.
					else if (!mem_req && !mem_ack)
						state <= vc_ctrl_pkg::UPDATE;
				end
				vc_ctrl_pkg::UPDATE:
				begin
					state <= vc_ctrl_pkg::RESPOND;
					ack <= 1'b1; // resp is already latched.
				end
				vc_ctrl_pkg::RESPOND:
				begin
					// no new request until the l1 lets go.
					if (!req)
					begin
						ack <= 1'b0;
						state <= vc_ctrl_pkg::IDLE;
					end
				end
				default: state <= vc_ctrl_pkg::IDLE;
			endcase
		end
	end

	// response and memory payload.
	// resp is taken in LOOKUP, before UPDATE overwrites the hit way.
	always_ff @(posedge clk)
	begin
		if (state == vc_ctrl_pkg::LOOKUP)
		begin
			if (lookup_hit)
				resp.data <= hit_data;
			mem_req_data <= victim_dirty ? wb_req : fetch_req;
		end
		else if (state == vc_ctrl_pkg::WRITEBACK && !mem_req && !mem_ack)
			mem_req_data <= fetch_req; // victim is out, switch to the read.
		else if (state == vc_ctrl_pkg::FETCH && mem_req && mem_ack)
			resp.data <= mem_resp.data;
	end

	// memory sees one payload for the whole request phase.
	mem_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && $past(mem_req) |-> $stable(mem_req_data))
	else
		$error("control: mem_req_data changed while mem_req was high.");

	// ack answers a live request, never a withdrawn one.
	ack_after_req : assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
	else
		$error("control: ack rose without a pending req.");

endmodule : victim_cache_control

`default_nettype wire

//--- rtl/victim_cache.sv
`timescale 1ns/10ps
`default_nettype none
`include "vc_consts.svh"

// four-way victim cache between an l1 and memory, top level.
module victim_cache
(
	input logic clk,
	input logic rst_n,
	input logic req,
	input vc_line_pkg::vc_req_t req_data,
	output logic ack,
	output vc_line_pkg::vc_resp_t resp,
	output logic mem_req,
	output vc_line_pkg::mem_req_t mem_req_data,
	input logic mem_ack,
	input vc_line_pkg::mem_resp_t mem_resp
);

	vc_line_pkg::vc_line_t [`VC_WAYS-1:0] way_lines;
	logic [`VC_WAYS-1:0][`VC_TAG_BITS-1:0] way_tags;
	vc_ctrl_pkg::vc_way_mask_t way_valid;
	vc_ctrl_pkg::vc_way_mask_t way_dirty;
	vc_ctrl_pkg::vc_way_mask_t hit_way;   // live match.
	vc_ctrl_pkg::vc_way_mask_t hit_way_q; // match held from LOOKUP.
	vc_ctrl_pkg::vc_way_t lru;
	logic update_victim;
	logic [1:0] new_access;
	logic load0;
	logic load1;
	logic load2;
	logic load3;
	vc_ctrl_pkg::vc_way_mask_t load_mask;
	vc_line_pkg::vc_line_t fill_line;

	// tag slice of each way for the compare.
	always_comb
	begin
		for (int i = 0; i < `VC_WAYS; i++)
		begin
			way_tags[i] = way_lines[i].tag;
		end
	end

	assign load_mask = {load3, load2, load1, load0};
	// the evicted line goes in on a hit and on a miss alike.
	assign fill_line = '{tag: req_data.evict_tag, data: req_data.evict_data};

	victim_cache_control control_inst
	(
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_data(req_data), .ack(ack), .resp(resp),
		.mem_req(mem_req), .mem_req_data(mem_req_data),
		.mem_ack(mem_ack), .mem_resp(mem_resp),
		.hit_way(hit_way), .lru(lru), .lines(way_lines),
		.dirty(way_dirty), .valid(way_valid),
		.hit_way_q(hit_way_q), .update_victim(update_victim)
	);

	victim_cache_tag_match tag_match_inst
	(
		.tags(way_tags), .valid(way_valid), .miss_tag(req_data.miss_tag), .hit_way(hit_way)
	);

	victim_cache_plru plru_inst
	(
		.clk(clk), .rst_n(rst_n),
		.touch(|load_mask), // any load counts as an access.
		.new_access(new_access), .valid(way_valid), .lru(lru)
	);

	victim_cache_victim_update_logic update_logic_inst
	(
		.update_victim(update_victim), .hit_way(hit_way_q), .lru(lru),
		.new_access(new_access),
		.load0(load0), .load1(load1), .load2(load2), .load3(load3)
	);

	victim_cache_ways ways_inst
	(
		.clk(clk), .rst_n(rst_n),
		.load(load_mask), .fill_line(fill_line), .fill_dirty(req_data.evict_dirty),
		.lines(way_lines), .valid(way_valid), .dirty(way_dirty)
	);

endmodule : victim_cache

`default_nettype wire

//--- verification/victim_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "vc_consts.svh"

// directed testbench for the victim cache, with a memory responder and a way model.
module victim_cache_tb;

	localparam int max_cycles = 4000; // about ten times the longest test.

	logic clk;
	logic rst_n;
	logic req;
	vc_line_pkg::vc_req_t req_data;
	logic ack;
	vc_line_pkg::vc_resp_t resp;
	logic mem_req;
	vc_line_pkg::mem_req_t mem_req_data;
	logic mem_ack;
	vc_line_pkg::mem_resp_t mem_resp;

	logic [`VC_LINE_BITS-1:0] mem_lines [logic [`VC_TAG_BITS-1:0]]; // memory behind the DUT.
	vc_line_pkg::mem_req_t mem_log [$]; // every transaction of the current access.
	int mem_writes = 0;
	int mem_txns = 0;
	int mem_wait = 0;

	// model of the four ways and the tree.
	logic [3:0] m_valid;
	logic [3:0] m_dirty;
	logic [`VC_TAG_BITS-1:0] m_tag [4];
	logic [`VC_LINE_BITS-1:0] m_data [4];
	logic [2:0] m_tree;
	logic [`VC_LINE_BITS-1:0] ref_mem [logic [`VC_TAG_BITS-1:0]]; // memory as the model sees it.

	logic [`VC_TAG_BITS-1:0] next_tag;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	victim_cache victim_cache_inst
	(
		.clk(clk), .rst_n(rst_n),
		.req(req), .req_data(req_data), .ack(ack), .resp(resp),
		.mem_req(mem_req), .mem_req_data(mem_req_data),
		.mem_ack(mem_ack), .mem_resp(mem_resp)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog.
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles.", max_cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// default line content carries the full tag in every word.
	function automatic logic [`VC_LINE_BITS-1:0] fill_of(input logic [`VC_TAG_BITS-1:0] t);
		logic [`VC_LINE_BITS-1:0] d;
		for (int i = 0; i < 8; i++)
			d[i*32 +: 32] = {t, 3'(i), 2'b01};
		return d;
	endfunction

	// four-phase memory responder with a short varying delay.
	initial
	begin
		mem_ack = 1'b0;
		mem_resp = '0;
		forever
		begin
			@(negedge clk);
			if (!rst_n)
				mem_ack = 1'b0;
			else if (mem_req && !mem_ack)
			begin
				if (mem_wait < mem_txns % 3)
					mem_wait++; // still busy.
				else
				begin
					mem_wait = 0;
					mem_txns++;
					mem_log.push_back(mem_req_data);
					if (mem_req_data.write)
					begin
						mem_writes++;
						mem_lines[mem_req_data.tag] = mem_req_data.data;
					end
					else if (mem_lines.exists(mem_req_data.tag))
						mem_resp.data = mem_lines[mem_req_data.tag];
					else
						mem_resp.data = fill_of(mem_req_data.tag);
					mem_ack = 1'b1;
				end
			end
			else if (!mem_req && mem_ack)
			begin
				mem_ack = 1'b0; // phase four.
				mem_resp = '0;
			end
		end
	end

	function automatic logic [`VC_LINE_BITS-1:0] ref_line(input logic [`VC_TAG_BITS-1:0] t);
		if (ref_mem.exists(t))
			return ref_mem[t];
		return fill_of(t);
	endfunction

	function automatic logic [`VC_LINE_BITS-1:0] rand_line();
		logic [`VC_LINE_BITS-1:0] d;
		for (int i = 0; i < 8; i++)
			d[i*32 +: 32] = $urandom;
		return d;
	endfunction

	function automatic logic [`VC_TAG_BITS-1:0] fresh_tag();
		next_tag = next_tag + 1'b1; // never resident, never seen before.
		return next_tag;
	endfunction

	function automatic int model_lookup(input logic [`VC_TAG_BITS-1:0] t);
		for (int i = 0; i < 4; i++)
			if (m_valid[i] && m_tag[i] == t)
				return i;
		return -1;
	endfunction

	// lowest empty way first, then the tree.
	function automatic int model_lru();
		for (int i = 0; i < 4; i++)
			if (!m_valid[i])
				return i;
		if (!m_tree[0])
			return m_tree[1] ? 1 : 0;
		return m_tree[2] ? 3 : 2;
	endfunction

	// bits on the path point away from the accessed way.
	task automatic model_touch(input int w);
		if (w < 2)
		begin
			m_tree[0] = 1'b1;
			m_tree[1] = (w == 0);
		end
		else
		begin
			m_tree[0] = 1'b0;
			m_tree[2] = (w == 2);
		end
	endtask

	function automatic vc_line_pkg::vc_req_t make_req(input logic [`VC_TAG_BITS-1:0] miss_tag,
		input logic ev_valid, input logic ev_dirty, input logic [`VC_TAG_BITS-1:0] ev_tag);
		vc_line_pkg::vc_req_t r;
		r.miss_tag = miss_tag;
		r.evict_valid = ev_valid;
		r.evict_dirty = ev_dirty;
		r.evict_tag = ev_tag;
		r.evict_data = ev_dirty ? rand_line() : ref_line(ev_tag); // clean lines match memory.
		return r;
	endfunction

	task automatic check_resp(input string what, input vc_line_pkg::vc_resp_t got,
		input vc_line_pkg::vc_resp_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got.data, exp.data);
		end
	endtask

	// data is compared only for writebacks.
	task automatic check_mem_write(input string what, input vc_line_pkg::mem_req_t got,
		input vc_line_pkg::mem_req_t exp);
		checks++;
		if (got.write !== exp.write || got.tag !== exp.tag || (exp.write && got.data !== exp.data))
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got write %b tag %h expected write %b tag %h",
				$time, what, got.write, got.tag, exp.write, exp.tag);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_int(input string what, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// one full l1 handshake checked against the model before the model steps.
	task automatic run_access(input vc_line_pkg::vc_req_t r);
		int h;
		int v;
		int lat;
		logic wb_on;
		vc_line_pkg::vc_resp_t exp_resp;
		vc_line_pkg::vc_resp_t got;
		vc_line_pkg::mem_req_t exp_wb;
		vc_line_pkg::mem_req_t exp_rd;
		h = model_lookup(r.miss_tag);
		v = (h >= 0) ? h : model_lru();
		exp_resp.data = (h >= 0) ? m_data[h] : ref_line(r.miss_tag);
		wb_on = (h < 0) && r.evict_valid && m_valid[v] && m_dirty[v];
		exp_wb = '{write: 1'b1, tag: m_tag[v], data: m_data[v]};
		exp_rd = '{write: 1'b0, tag: r.miss_tag, data: '0};
		mem_log.delete();
		@(negedge clk);
		req_data = r;
		req = 1'b1;
		lat = 0;
		do
		begin
			@(negedge clk);
			lat++;
		end
		while (!ack);
		got = resp;
		req = 1'b0;
		while (ack)
			@(negedge clk);
		check_resp("response line", got, exp_resp);
		check_bit("mem_req idle after access", mem_req, 1'b0);
		if (h >= 0)
			check_int("hit ack latency", lat, 3);
		check_int("memory transactions", mem_log.size(), (h >= 0) ? 0 : (wb_on ? 2 : 1));
		if (h < 0 && mem_log.size() == (wb_on ? 2 : 1))
		begin
			if (wb_on)
				check_mem_write("writeback", mem_log[0], exp_wb);
			check_mem_write("fetch", mem_log[mem_log.size()-1], exp_rd); // read comes last.
		end
		if (wb_on)
			ref_mem[m_tag[v]] = m_data[v];
		if (r.evict_valid)
		begin
			m_valid[v] = 1'b1;
			m_dirty[v] = r.evict_dirty;
			m_tag[v] = r.evict_tag;
			m_data[v] = r.evict_data;
			model_touch(v);
		end
	endtask

	task automatic end_test(input string name, input int e0);
		tests_run++;
		if (errors == e0)
			$display("test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - e0);
		end
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_bit("ack after reset", ack, 1'b0);
		check_bit("mem_req after reset", mem_req, 1'b0);
		run_access(make_req(fresh_tag(), 1'b1, 1'b0, fresh_tag())); // empty way, no writeback.
		end_test("reset", e0);
	endtask

	task automatic test_hit();
		logic [`VC_TAG_BITS-1:0] t [4];
		int e0;
		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			t[i] = fresh_tag();
			run_access(make_req(fresh_tag(), 1'b1, 1'b0, t[i]));
		end
		run_access(make_req(t[3], 1'b1, 1'b0, fresh_tag()));
		run_access(make_req(t[1], 1'b1, 1'b0, fresh_tag()));
		end_test("hit", e0);
	endtask

	task automatic test_swap();
		logic [`VC_TAG_BITS-1:0] a;
		logic [`VC_TAG_BITS-1:0] b;
		int e0;
		e0 = errors;
		a = m_tag[3];
		b = fresh_tag();
		run_access(make_req(a, 1'b1, 1'b1, b));           // hit on a while b takes its way.
		run_access(make_req(b, 1'b1, 1'b0, fresh_tag())); // b is found.
		run_access(make_req(a, 1'b1, 1'b0, fresh_tag())); // a is gone.
		end_test("swap", e0);
	endtask

	task automatic test_plru();
		logic [`VC_TAG_BITS-1:0] old;
		int e0;
		e0 = errors;
		for (int k = 0; k < 4; k++)
		begin
			old = m_tag[model_lru()];
			run_access(make_req(fresh_tag(), 1'b1, 1'b0, fresh_tag()));
			run_access(make_req(old, 1'b1, 1'b0, fresh_tag())); // replaced line misses.
		end
		end_test("plru", e0);
	endtask

	task automatic test_dirty();
		logic [`VC_TAG_BITS-1:0] d;
		int w0;
		int e0;
		e0 = errors;
		d = fresh_tag();
		run_access(make_req(fresh_tag(), 1'b1, 1'b1, d));
		w0 = mem_writes;
		for (int k = 0; k < 6 && model_lookup(d) >= 0; k++)
			run_access(make_req(fresh_tag(), 1'b1, 1'b0, fresh_tag()));
		check_int("writebacks of the dirty line", mem_writes - w0, 1);
		w0 = mem_writes;
		run_access(make_req(fresh_tag(), 1'b1, 1'b0, fresh_tag())); // clean victim.
		check_int("writebacks of a clean victim", mem_writes - w0, 0);
		run_access(make_req(d, 1'b1, 1'b0, fresh_tag())); // written data comes back.
		end_test("dirty", e0);
	endtask

	task automatic test_random();
		logic [`VC_TAG_BITS-1:0] mt;
		int w;
		int e0;
		e0 = errors;
		for (int k = 0; k < 30; k++)
		begin
			w = $urandom % 4;
			if ($urandom % 2 && m_valid[w])
				mt = m_tag[w]; // resident so a hit.
			else
				mt = fresh_tag();
			run_access(make_req(mt, ($urandom % 4) != 0, 1'($urandom % 2), fresh_tag()));
		end
		end_test("random", e0);
	endtask

	initial
	begin
		void'($urandom(32'h80817f18));
		rst_n = 1'b0;
		req = 1'b0;
		req_data = '0;
		next_tag = 27'h0001000;
		m_valid = '0;
		m_dirty = '0;
		m_tree = 3'b000;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_hit();
		test_swap();
		test_plru();
		test_dirty();
		test_random();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule : victim_cache_tb

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/vc_line_pkg.sv
rtl/vc_ctrl_pkg.sv
rtl/victim_cache_tag_match.sv
rtl/victim_cache_plru.sv
rtl/victim_cache_victim_update_logic.sv
rtl/victim_cache_ways.sv
rtl/victim_cache_control.sv
rtl/victim_cache.sv
verification/victim_cache_tb.sv

//--- Bender.yml
package:
  name: victim_cache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vc_line_pkg.sv
      - rtl/vc_ctrl_pkg.sv
      - rtl/victim_cache_tag_match.sv
      - rtl/victim_cache_plru.sv
      - rtl/victim_cache_victim_update_logic.sv
      - rtl/victim_cache_ways.sv
      - rtl/victim_cache_control.sv
      - rtl/victim_cache.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/victim_cache_tb.sv
